// File: cache_geom_pkg.sv
// cache geometry: address split, line layout and typed vectors for meaningful widths
package cache_geom_pkg;

    localparam int TAG_W    = 20;
    localparam int INDEX_W  = 8;
    localparam int OFFSET_W = 4;
    localparam int BANKS    = 4;
    localparam int WORD_W   = 32;
    localparam int LINE_W   = 128;
    localparam int SETS     = 256;

    // physical tag, addr[31:12]
    typedef logic [TAG_W-1:0]           tag_t;
    // set index, addr[11:4]
    typedef logic [INDEX_W-1:0]         index_t;
    // byte within the line
    typedef logic [OFFSET_W-1:0]        offset_t;
    // word within the line, upper two offset bits
    typedef logic [$clog2(BANKS)-1:0]   bank_t;
    typedef logic [WORD_W-1:0]          word_t;
    typedef logic [WORD_W/8-1:0]        strb_t;
    // bank 0 sits in the low word
    typedef logic [LINE_W-1:0]          line_t;
    typedef logic [TAG_W+INDEX_W+OFFSET_W-1:0] addr_t;
    typedef logic                       way_t;

    // line-aligned address of a set in a given tag
    function automatic addr_t line_addr(tag_t tag, index_t index);
        return {tag, index, {OFFSET_W{1'b0}}};
    endfunction

endpackage

// File: cache_bus_pkg.sv
// request and command formats on the cpu, memory and internal store buses
package cache_bus_pkg;

    import cache_geom_pkg::*;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } cache_op_e;

    // one cpu access
    typedef struct packed {
        cache_op_e op;
        tag_t      tag;
        index_t    index;
        offset_t   offset;
        strb_t     wstrb;
        word_t     wdata;
    } cpu_req_t;

    // whole-line read from memory
    typedef struct packed {
        addr_t addr;
    } mem_rd_req_t;

    // whole-line write-back, data moves in one cycle
    typedef struct packed {
        addr_t addr;
        line_t line;
    } mem_wr_req_t;

    // tag store entry of one way
    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } tag_entry_t;

    // refill update of the tag store
    typedef struct packed {
        way_t   way;
        index_t index;
        tag_t   tag;
        logic   dirty;
    } tag_wr_t;

    // one bank write, hit store or refill beat
    typedef struct packed {
        way_t   way;
        index_t index;
        bank_t  bank;
        strb_t  strb;
        word_t  data;
    } data_wr_t;

endpackage

// File: cache_tag_store.sv
// two-way tag store holding valid, dirty and tag per set, with per-way hit compare
`timescale 1ns/1ns

module cache_tag_store
    import cache_geom_pkg::*;
    import cache_bus_pkg::*;
(
    input  logic             clk,
    input  logic             resetn,
    input  logic             rd_en,
    input  index_t           rd_index,
    input  tag_t             cmp_tag,
    input  logic             tag_we,
    input  tag_wr_t          tag_wr,
    input  logic             dirty_set,
    input  way_t             dirty_way,
    input  index_t           dirty_index,
    output tag_entry_t [1:0] entry,
    output logic [1:0]       hit
);

    logic [1:0][SETS-1:0] valid_q;
    logic [1:0][SETS-1:0] dirty_q;
    tag_t                 tag_mem [2][SETS];

    // valid and dirty bits
    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (tag_we) begin
            valid_q[tag_wr.way][tag_wr.index] <= 1'b1;
            dirty_q[tag_wr.way][tag_wr.index] <= tag_wr.dirty;  // dirty when the miss was a store
        end else if (dirty_set) begin
            dirty_q[dirty_way][dirty_index] <= 1'b1;  // store hit
        end
    end

    always_ff @(posedge clk) begin
        if (tag_we) begin
            tag_mem[tag_wr.way][tag_wr.index] <= tag_wr.tag;
        end
    end

    // read both ways, held until the next lookup
    always_ff @(posedge clk) begin
        if (!resetn) begin
            entry <= '0;
        end else if (rd_en) begin
            for (int w = 0; w < 2; w++) begin
                entry[w].valid <= valid_q[w][rd_index];
                entry[w].dirty <= dirty_q[w][rd_index];
                entry[w].tag   <= tag_mem[w][rd_index];
            end
        end
    end

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            hit[w] = entry[w].valid && (entry[w].tag == cmp_tag);
        end
    end

    // refill only ever fills the missing tag, so a set never holds it twice
    a_one_hit : assert property (
        @(posedge clk) disable iff (!resetn)
        !(hit[0] && hit[1])
    );

endmodule

// File: cache_data_store.sv
// data store of two ways, four byte-writable 32-bit banks each, read a whole line at a time
`timescale 1ns/1ns

module cache_data_store
    import cache_geom_pkg::*;
    import cache_bus_pkg::*;
(
    input  logic        clk,
    input  logic        rd_en,
    input  index_t      rd_index,
    input  logic        data_we,
    input  data_wr_t    data_wr,
    output line_t [1:0] line
);

    word_t bank_mem [2][BANKS][SETS];
    word_t wr_old;
    word_t wr_new;

    // current contents of the bank being written
    assign wr_old = bank_mem[data_wr.way][data_wr.bank][data_wr.index];

    // merge strobed bytes over the stored word
    always_comb begin
        wr_new = wr_old;
        for (int b = 0; b < WORD_W/8; b++) begin
            if (data_wr.strb[b]) begin
                wr_new[8*b +: 8] = data_wr.data[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (data_we) begin
            bank_mem[data_wr.way][data_wr.bank][data_wr.index] <= wr_new;
        end
    end

    // every bank of both ways, bank 0 in the low word
    always_ff @(posedge clk) begin
        if (rd_en) begin
            for (int w = 0; w < 2; w++) begin
                for (int k = 0; k < BANKS; k++) begin
                    line[w][WORD_W*k +: WORD_W] <= bank_mem[w][k][rd_index];
                end
            end
        end
    end

    // controller filters empty stores, refill always writes the full word
    a_strb_nonzero : assert property (
        @(posedge clk)
        data_we |-> (data_wr.strb != '0)
    );

endmodule

// File: cache_ctrl.sv
// cache controller: lookup FSM, request buffer, refill counter, victim LFSR and memory requests
`timescale 1ns/1ns

module cache_ctrl
    import cache_geom_pkg::*;
    import cache_bus_pkg::*;
(
    input  logic             clk,
    input  logic             resetn,
    input  logic             valid,
    input  cpu_req_t         req,
    output logic             addr_ok,
    output logic             data_ok,
    output word_t            rdata,
    input  logic [1:0]       hit,
    input  tag_entry_t [1:0] entry,
    input  line_t [1:0]      line,
    output logic             rd_en,
    output index_t           rd_index,
    output tag_t             cmp_tag,
    output logic             tag_we,
    output tag_wr_t          tag_wr,
    output logic             data_we,
    output data_wr_t         data_wr,
    output logic             dirty_set,
    output logic             rd_req,
    output mem_rd_req_t      rd_req_data,
    input  logic             rd_rdy,
    input  logic             ret_valid,
    input  logic             ret_last,
    input  word_t            ret_data,
    output logic             wr_req,
    output mem_wr_req_t      wr_req_data,
    input  logic             wr_rdy
);

    typedef enum logic [2:0] {IDLE, LOOKUP, MISS, REPLACE, REFILL} state_e;

    state_e     state;
    state_e     state_nxt;
    cpu_req_t   req_q;      // request buffer
    bank_t      beat_cnt;   // refill beats seen
    logic [2:0] lfsr;
    bank_t      req_bank;
    way_t       hit_way;
    way_t       victim;
    logic       cache_hit;
    logic       victim_dirty;
    logic       wr_hit;
    logic       req_beat;
    logic       last_beat;
    word_t      hit_word;
    word_t      fill_word;

    assign addr_ok  = (state == IDLE);  // one request in flight
    assign rd_en    = valid && addr_ok;
    assign rd_index = req.index;
    assign cmp_tag  = req_q.tag;

    always_ff @(posedge clk) begin
        if (rd_en) begin
            req_q <= req;
        end
    end

    assign req_bank     = req_q.offset[OFFSET_W-1:2];
    assign cache_hit    = |hit;
    assign hit_way      = hit[1];
    assign hit_word     = line[hit_way][WORD_W*req_bank +: WORD_W];
    assign wr_hit       = (state == LOOKUP) && cache_hit && (req_q.op == OP_WRITE);
    assign victim       = lfsr[0];
    assign victim_dirty = entry[victim].valid && entry[victim].dirty;
    assign req_beat     = (state == REFILL) && ret_valid && (beat_cnt == req_bank);
    assign last_beat    = (state == REFILL) && ret_valid && ret_last;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:    if (rd_en) state_nxt = LOOKUP;
            LOOKUP:  state_nxt = cache_hit ? IDLE : MISS;
            MISS:    if (!victim_dirty || wr_rdy) state_nxt = REPLACE;  // wait for write-back
            REPLACE: if (rd_rdy) state_nxt = REFILL;
            REFILL:  if (last_beat) state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            beat_cnt <= '0;
        end else if ((state == REFILL) && ret_valid) begin
            beat_cnt <= ret_last ? '0 : beat_cnt + 1'b1;
        end
    end

    // steps once per refilled line
    always_ff @(posedge clk) begin
        if (!resetn) begin
            lfsr <= 3'b111;
        end else if (last_beat) begin
            lfsr <= {lfsr[0], lfsr[2] ^ lfsr[0], lfsr[1]};
        end
    end

    // store bytes win over memory data in the requested bank
    always_comb begin
        fill_word = ret_data;
        if ((req_q.op == OP_WRITE) && (beat_cnt == req_bank)) begin
            for (int b = 0; b < WORD_W/8; b++) begin
                if (req_q.wstrb[b]) begin
                    fill_word[8*b +: 8] = req_q.wdata[8*b +: 8];
                end
            end
        end
    end

    always_comb begin
        if (state == REFILL) begin
            data_we = ret_valid;
            data_wr = '{way: victim, index: req_q.index, bank: beat_cnt,
                        strb: '1, data: fill_word};
        end else begin
            data_we = wr_hit && (req_q.wstrb != '0);  // empty strobe stores nothing
            data_wr = '{way: hit_way, index: req_q.index, bank: req_bank,
                        strb: req_q.wstrb, data: req_q.wdata};
        end
    end

    assign dirty_set = wr_hit;
    assign tag_we    = req_beat;
    assign tag_wr    = '{way: victim, index: req_q.index, tag: req_q.tag,
                         dirty: (req_q.op == OP_WRITE)};

    assign data_ok = ((state == LOOKUP) && cache_hit) || req_beat;
    assign rdata   = (state == REFILL) ? ret_data : hit_word;

    assign rd_req           = (state == REPLACE);
    assign rd_req_data.addr = line_addr(req_q.tag, req_q.index);

    // victim line as read during lookup
    assign wr_req           = (state == MISS) && victim_dirty;
    assign wr_req_data.addr = line_addr(entry[victim].tag, req_q.index);
    assign wr_req_data.line = line[victim];

    a_rd_wr_excl : assert property (
        @(posedge clk) disable iff (!resetn)
        !(rd_req && wr_req)
    );

    a_data_ok_busy : assert property (
        @(posedge clk) disable iff (!resetn)
        data_ok |-> (state != IDLE)
    );

endmodule

// File: cache_top.sv
// two-way write-back data cache: controller plus tag and data stores
`timescale 1ns/1ns

module cache_top
    import cache_geom_pkg::*;
    import cache_bus_pkg::*;
(
    input  logic        clk,
    input  logic        resetn,
    input  logic        valid,
    input  cpu_req_t    req,
    output logic        addr_ok,
    output logic        data_ok,
    output word_t       rdata,
    output logic        rd_req,
    output mem_rd_req_t rd_req_data,
    input  logic        rd_rdy,
    input  logic        ret_valid,
    input  logic        ret_last,
    input  word_t       ret_data,
    output logic        wr_req,
    output mem_wr_req_t wr_req_data,
    input  logic        wr_rdy
);

    logic [1:0]       hit;
    tag_entry_t [1:0] entry;
    line_t [1:0]      line;
    logic             rd_en;
    index_t           rd_index;
    tag_t             cmp_tag;
    logic             tag_we;
    tag_wr_t          tag_wr;
    logic             data_we;
    data_wr_t         data_wr;
    logic             dirty_set;

    cache_ctrl i_cache_ctrl (
        .clk         (clk),
        .resetn      (resetn),
        .valid       (valid),
        .req         (req),
        .addr_ok     (addr_ok),
        .data_ok     (data_ok),
        .rdata       (rdata),
        .hit         (hit),
        .entry       (entry),
        .line        (line),
        .rd_en       (rd_en),
        .rd_index    (rd_index),
        .cmp_tag     (cmp_tag),
        .tag_we      (tag_we),
        .tag_wr      (tag_wr),
        .data_we     (data_we),
        .data_wr     (data_wr),
        .dirty_set   (dirty_set),
        .rd_req      (rd_req),
        .rd_req_data (rd_req_data),
        .rd_rdy      (rd_rdy),
        .ret_valid   (ret_valid),
        .ret_last    (ret_last),
        .ret_data    (ret_data),
        .wr_req      (wr_req),
        .wr_req_data (wr_req_data),
        .wr_rdy      (wr_rdy)
    );

    // store hit marks the line it wrote
    cache_tag_store i_cache_tag_store (
        .clk         (clk),
        .resetn      (resetn),
        .rd_en       (rd_en),
        .rd_index    (rd_index),
        .cmp_tag     (cmp_tag),
        .tag_we      (tag_we),
        .tag_wr      (tag_wr),
        .dirty_set   (dirty_set),
        .dirty_way   (data_wr.way),
        .dirty_index (data_wr.index),
        .entry       (entry),
        .hit         (hit)
    );

    cache_data_store i_cache_data_store (
        .clk      (clk),
        .rd_en    (rd_en),
        .rd_index (rd_index),
        .data_we  (data_we),
        .data_wr  (data_wr),
        .line     (line)
    );

endmodule

// File: tb_clk_gen.sv
// testbench clock and reset source, 10 ns clock with reset held low for the first cycles
`timescale 1ns/1ns

module tb_clk_gen (
    output logic clk,
    output logic resetn
);

    localparam int RESET_CYCLES = 5;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        resetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        resetn <= 1'b1;  // released on a rising edge
    end

endmodule

// File: tb_cache.sv
// testbench for the two-way data cache with random cpu traffic, a memory responder and a shadow model
`timescale 1ns/1ns

module tb_cache
    import cache_geom_pkg::*;
    import cache_bus_pkg::*;
();

    localparam int NUM_REQ = 400;
    localparam int MAX_CYC = NUM_REQ * 40;  // worst miss with stalls and gaps stays well below 40
    localparam tag_t   TAG_LIST   [4] = '{20'h00000, 20'h00001, 20'h5a3c1, 20'hfffff};
    localparam index_t INDEX_LIST [4] = '{8'h00, 8'h01, 8'h80, 8'hff};

    logic        clk;
    logic        resetn;
    logic        valid;
    cpu_req_t    req;
    logic        addr_ok;
    logic        data_ok;
    word_t       rdata;
    logic        rd_req;
    mem_rd_req_t rd_req_data;
    logic        rd_rdy;
    logic        ret_valid;
    logic        ret_last;
    word_t       ret_data;
    logic        wr_req;
    mem_wr_req_t wr_req_data;
    logic        wr_rdy;

    word_t       mem_model [64];  // what memory holds
    word_t       image [64];      // what the cpu has written
    logic        sh_valid [4][2];
    logic        sh_dirty [4][2];
    logic [1:0]  sh_tag [4][2];   // tag as a TAG_LIST selector
    logic [2:0]  sh_lfsr;
    logic [31:0] rng;
    int          cycles = 0;

    tb_clk_gen i_tb_clk_gen (
        .clk    (clk),
        .resetn (resetn)
    );

    cache_top i_cache_top (
        .clk         (clk),
        .resetn      (resetn),
        .valid       (valid),
        .req         (req),
        .addr_ok     (addr_ok),
        .data_ok     (data_ok),
        .rdata       (rdata),
        .rd_req      (rd_req),
        .rd_req_data (rd_req_data),
        .rd_rdy      (rd_rdy),
        .ret_valid   (ret_valid),
        .ret_last    (ret_last),
        .ret_data    (ret_data),
        .wr_req      (wr_req),
        .wr_req_data (wr_req_data),
        .wr_rdy      (wr_rdy)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            rng = lfsr_step(rng);  // one step per bit
            v   = {v[30:0], rng[0]};
        end
        return v;
    endfunction

    function automatic addr_t word_addr(logic [1:0] tsel, logic [1:0] isel, bank_t bank);
        return {TAG_LIST[tsel], INDEX_LIST[isel], bank, 2'b00};
    endfunction

    function automatic int word_index(logic [1:0] tsel, logic [1:0] isel, int bank);
        return tsel * 16 + isel * 4 + bank;
    endfunction

    function automatic word_t merge_bytes(word_t old, word_t data, strb_t strb);
        word_t w;
        w = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) w[8*b +: 8] = data[8*b +: 8];
        end
        return w;
    endfunction

    task automatic check_value(string name, logic [127:0] actual, logic [127:0] expected);
        if (actual !== expected) begin
            $display("ERROR: %s actual=%0h expected=%0h", name, actual, expected);
            $display("Verification failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // line as the program sees it with bank 0 low
    function automatic line_t image_line(logic [1:0] tsel, logic [1:0] isel);
        return {image[word_index(tsel, isel, 3)], image[word_index(tsel, isel, 2)],
                image[word_index(tsel, isel, 1)], image[word_index(tsel, isel, 0)]};
    endfunction

    task automatic run_request();
        cpu_req_t   r;
        logic [1:0] tsel;
        logic [1:0] isel;
        bank_t      bank;
        logic       pred_hit;
        way_t       way;
        int         stall;
        int         gap;
        int         widx;
        line_t      wb_line;

        r.op     = (take_bits(1) == 32'd1) ? OP_WRITE : OP_READ;
        tsel     = 2'(take_bits(2));
        isel     = 2'(take_bits(2));
        bank     = bank_t'(take_bits(2));
        r.tag    = TAG_LIST[tsel];
        r.index  = INDEX_LIST[isel];
        r.offset = {bank, 2'b00};
        r.wstrb  = (r.op == OP_WRITE) ? strb_t'(take_bits(4)) : '0;
        r.wdata  = take_bits(32);
        widx     = word_index(tsel, isel, int'(bank));

        pred_hit = 1'b0;
        way      = sh_lfsr[0];  // victim unless a way already holds the line
        for (int w = 0; w < 2; w++) begin
            if (sh_valid[isel][w] && sh_tag[isel][w] == tsel) begin
                pred_hit = 1'b1;
                way      = way_t'(w);
            end
        end

        @(negedge clk);
        while (addr_ok !== 1'b1) @(negedge clk);
        @(posedge clk);
        valid <= 1'b1;
        req   <= r;
        @(posedge clk);  // accepted on this edge
        valid <= 1'b0;
        @(negedge clk);
        check_value("data_ok", 128'(data_ok), 128'(pred_hit));
        check_value("rd_req", 128'(rd_req), 128'(0));
        check_value("wr_req", 128'(wr_req), 128'(0));

        if (pred_hit) begin
            if (r.op == OP_READ) begin
                check_value("rdata", 128'(rdata), 128'(image[widx]));
            end else begin
                image[widx]         = merge_bytes(image[widx], r.wdata, r.wstrb);
                sh_dirty[isel][way] = 1'b1;
            end
            @(negedge clk);
            check_value("addr_ok", 128'(addr_ok), 128'(1));
            check_value("data_ok", 128'(data_ok), 128'(0));
        end else begin
            @(negedge clk);
            check_value("wr_req", 128'(wr_req), 128'(sh_valid[isel][way] && sh_dirty[isel][way]));
            check_value("rd_req", 128'(rd_req), 128'(0));
            if (sh_valid[isel][way] && sh_dirty[isel][way]) begin
                wb_line = image_line(sh_tag[isel][way], isel);
                check_value("wr_req_data.addr", 128'(wr_req_data.addr),
                            128'(word_addr(sh_tag[isel][way], isel, 2'd0)));
                check_value("wr_req_data.line", 128'(wr_req_data.line), 128'(wb_line));
                stall   = int'(take_bits(2));
                repeat (stall) begin
                    @(negedge clk);
                    check_value("wr_req", 128'(wr_req), 128'(1));
                    check_value("wr_req_data.line", 128'(wr_req_data.line), 128'(wb_line));
                end
                @(posedge clk);
                wr_rdy <= 1'b1;
                @(posedge clk);
                wr_rdy <= 1'b0;
                for (int k = 0; k < BANKS; k++) begin
                    mem_model[word_index(sh_tag[isel][way], isel, k)] = wb_line[WORD_W*k +: WORD_W];
                end
            end

            @(negedge clk);
            check_value("rd_req", 128'(rd_req), 128'(1));
            check_value("wr_req", 128'(wr_req), 128'(0));
            check_value("rd_req_data.addr", 128'(rd_req_data.addr),
                        128'(word_addr(tsel, isel, 2'd0)));
            stall = int'(take_bits(2));
            repeat (stall) begin
                @(negedge clk);
                check_value("rd_req", 128'(rd_req), 128'(1));
            end
            @(posedge clk);
            rd_rdy <= 1'b1;
            @(posedge clk);
            rd_rdy <= 1'b0;

            // refill beats in word order with random gaps
            for (int b = 0; b < BANKS; b++) begin
                gap = int'(take_bits(2));
                repeat (gap) begin
                    @(posedge clk);
                    ret_valid <= 1'b0;
                    @(negedge clk);
                    check_value("data_ok", 128'(data_ok), 128'(0));
                end
                @(posedge clk);
                ret_valid <= 1'b1;
                ret_last  <= (b == BANKS - 1);
                ret_data  <= mem_model[word_index(tsel, isel, b)];
                @(negedge clk);
                check_value("data_ok", 128'(data_ok), 128'(b == int'(bank)));
                if (b == int'(bank) && r.op == OP_READ) begin
                    check_value("rdata", 128'(rdata), 128'(image[widx]));
                end
            end
            @(posedge clk);
            ret_valid <= 1'b0;
            ret_last  <= 1'b0;
            @(negedge clk);
            check_value("addr_ok", 128'(addr_ok), 128'(1));

            sh_valid[isel][way] = 1'b1;
            sh_tag[isel][way]   = tsel;
            sh_dirty[isel][way] = (r.op == OP_WRITE);
            sh_lfsr             = {sh_lfsr[0], sh_lfsr[2] ^ sh_lfsr[0], sh_lfsr[1]};
            if (r.op == OP_WRITE) begin
                image[widx] = merge_bytes(image[widx], r.wdata, r.wstrb);
            end
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYC) begin
            $display("timeout: run still busy after %0d cycles", MAX_CYC);
            $display("Verification failed");
            $fatal(1, "timeout");
        end
    end

    initial begin
        rng       = 32'h3f7b;
        sh_lfsr   = 3'b111;
        valid     <= 1'b0;
        req       <= '0;
        rd_rdy    <= 1'b0;
        ret_valid <= 1'b0;
        ret_last  <= 1'b0;
        ret_data  <= '0;
        wr_rdy    <= 1'b0;
        for (int i = 0; i < 64; i++) begin
            mem_model[i] = ~word_addr(2'(i >> 4), 2'(i >> 2), bank_t'(i));
            image[i]     = mem_model[i];
        end
        for (int s = 0; s < 4; s++) begin
            for (int w = 0; w < 2; w++) begin
                sh_valid[s][w] = 1'b0;
                sh_dirty[s][w] = 1'b0;
                sh_tag[s][w]   = 2'd0;
            end
        end

        while (resetn !== 1'b1) @(negedge clk);
        check_value("addr_ok", 128'(addr_ok), 128'(1));
        check_value("data_ok", 128'(data_ok), 128'(0));
        check_value("rd_req", 128'(rd_req), 128'(0));
        check_value("wr_req", 128'(wr_req), 128'(0));

        repeat (NUM_REQ) run_request();

        $display("Verification passed");
        $finish;
    end

endmodule

// File: cache.f
cache_geom_pkg.sv
cache_bus_pkg.sv
cache_tag_store.sv
cache_data_store.sv
cache_ctrl.sv
cache_top.sv
tb_clk_gen.sv
tb_cache.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_cache
FILELIST  = cache.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "Verification passed" $(LOG); then echo "FAIL"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(BUILD) $(LOG)
